/* design/fm_lfo.sv */
`default_nettype none

module fm_lfo (
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic                     frame_tick,
    input  logic [3:0]               lfo_rate,
    input  logic [fm_pkg::pmd_w-1:0] pmd,
    output logic [fm_pkg::mod_w-1:0] mod,
    output logic                     mod_add
);

    logic [3:0]  presc;
    logic [7:0]  tri_ph;
    logic [7:0]  tri_nx;
    logic [5:0]  ramp;
    logic [6:0]  mag;
    logic [13:0] scaled;
    logic        lfo_step;

    assign lfo_step = frame_tick && (presc == lfo_rate);
    assign tri_nx   = tri_ph + 8'd1;

    // the second and fourth quarters run the ramp backwards, bit 7 is the sign.
    assign ramp     = tri_nx[6] ? ~tri_nx[5:0] : tri_nx[5:0];
    assign mag      = {ramp, 1'b0};
    assign scaled   = mag * pmd;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            presc   <= '0;
            tri_ph  <= '0;
            mod     <= '0;
            mod_add <= 1'b1;
        end else if (frame_tick) begin
            if (lfo_step) begin
                presc   <= '0;
                tri_ph  <= tri_nx;
                mod     <= scaled[13:5];
                mod_add <= !tri_nx[7] || (ramp == 6'd0);
            end else begin
                presc <= presc + 4'd1;
            end
        end
    end

endmodule

`default_nettype wire

/* design/fm_pg_top.sv */
`default_nettype none

module fm_pg_top (
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic                       wr_valid,
    output logic                       wr_ready,
    input  logic [fm_pkg::chan_w-1:0]  wr_chan,
    input  logic [fm_pkg::kc_w-1:0]    wr_kc,
    input  logic [fm_pkg::kf_w-1:0]    wr_kf,
    input  logic [fm_pkg::pmd_w-1:0]   pmd,
    input  logic [3:0]                 lfo_rate,
    output logic                       out_valid,
    input  logic                       out_ready,
    output logic [fm_pkg::chan_w-1:0]  out_chan,
    output logic [fm_pkg::phase_w-1:0] out_phase
);

    logic                      wr_en;
    logic                      slot_valid;
    logic [fm_pkg::chan_w-1:0] slot_chan;
    logic                      stall;
    logic                      frame_tick;
    logic [fm_pkg::kc_w-1:0]   kc;
    logic [fm_pkg::kf_w-1:0]   kf;
    logic [fm_pkg::mod_w-1:0]  mod;
    logic                      mod_add;
    logic [fm_pkg::kcex_w-1:0] kcex;
    logic [fm_pkg::inc_w-1:0]  inc;
    logic                      inc_valid;
    logic [fm_pkg::chan_w-1:0] inc_chan;

    assign wr_en = wr_valid && wr_ready;

    fm_slot_ctrl u_ctrl (
        .clk        (clk),
        .arst_n     (arst_n),
        .wr_ready   (wr_ready),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .slot_valid (slot_valid),
        .slot_chan  (slot_chan),
        .stall      (stall),
        .frame_tick (frame_tick)
    );

    fm_lfo u_lfo (
        .clk        (clk),
        .arst_n     (arst_n),
        .frame_tick (frame_tick),
        .lfo_rate   (lfo_rate),
        .pmd        (pmd),
        .mod        (mod),
        .mod_add    (mod_add)
    );

    fm_pm_keycode u_keycode (
        .kc      (kc),
        .kf      (kf),
        .mod     (mod),
        .mod_add (mod_add),
        .kcex    (kcex)
    );

    fm_phase_inc u_inc (
        .clk        (clk),
        .arst_n     (arst_n),
        .stall      (stall),
        .slot_valid (slot_valid),
        .slot_chan  (slot_chan),
        .kcex       (kcex),
        .inc        (inc),
        .inc_valid  (inc_valid),
        .inc_chan   (inc_chan)
    );

    fm_phase_acc u_acc (
        .clk       (clk),
        .arst_n    (arst_n),
        .stall     (stall),
        .wr_en     (wr_en),
        .wr_chan   (wr_chan),
        .wr_kc     (wr_kc),
        .wr_kf     (wr_kf),
        .slot_chan (slot_chan),
        .kc        (kc),
        .kf        (kf),
        .inc       (inc),
        .inc_valid (inc_valid),
        .inc_chan  (inc_chan),
        .out_valid (out_valid),
        .out_chan  (out_chan),
        .out_phase (out_phase)
    );

endmodule

`default_nettype wire

/* design/fm_phase_acc.sv */
`default_nettype none

module fm_phase_acc (
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic                       stall,
    input  logic                       wr_en,
    input  logic [fm_pkg::chan_w-1:0]  wr_chan,
    input  logic [fm_pkg::kc_w-1:0]    wr_kc,
    input  logic [fm_pkg::kf_w-1:0]    wr_kf,
    input  logic [fm_pkg::chan_w-1:0]  slot_chan,
    output logic [fm_pkg::kc_w-1:0]    kc,
    output logic [fm_pkg::kf_w-1:0]    kf,
    input  logic [fm_pkg::inc_w-1:0]   inc,
    input  logic                       inc_valid,
    input  logic [fm_pkg::chan_w-1:0]  inc_chan,
    output logic                       out_valid,
    output logic [fm_pkg::chan_w-1:0]  out_chan,
    output logic [fm_pkg::phase_w-1:0] out_phase
);

    logic [fm_pkg::kc_w-1:0]    kc_mem [fm_pkg::num_chan];
    logic [fm_pkg::kf_w-1:0]    kf_mem [fm_pkg::num_chan];
    logic [fm_pkg::phase_w-1:0] ph_mem [fm_pkg::num_chan];
    logic [fm_pkg::phase_w-1:0] ph_sum;
    logic                       acc_en;

    assign kc     = kc_mem[slot_chan];
    assign kf     = kf_mem[slot_chan];
    assign acc_en = inc_valid && !stall;

    // the phase simply wraps around.
    assign ph_sum = ph_mem[inc_chan] + {{(fm_pkg::phase_w - fm_pkg::inc_w){1'b0}}, inc};

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < fm_pkg::num_chan; i++) begin
                kc_mem[i] <= '0;
                kf_mem[i] <= '0;
                ph_mem[i] <= '0;
            end
            out_valid <= 1'b0;
        end else begin
            if (wr_en) begin
                kc_mem[wr_chan] <= wr_kc;
                kf_mem[wr_chan] <= wr_kf;
            end
            if (acc_en) begin
                ph_mem[inc_chan] <= ph_sum;
            end
            // not stalled while valid means the held word was taken this cycle.
            if (!stall) begin
                out_valid <= inc_valid;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (acc_en) begin
            out_chan  <= inc_chan;
            out_phase <= ph_sum;
        end
    end

endmodule

`default_nettype wire

/* design/fm_phase_inc.sv */
`default_nettype none

module fm_phase_inc (
    input  logic                      clk,
    input  logic                      arst_n,
    input  logic                      stall,
    input  logic                      slot_valid,
    input  logic [fm_pkg::chan_w-1:0] slot_chan,
    input  logic [fm_pkg::kcex_w-1:0] kcex,
    output logic [fm_pkg::inc_w-1:0]  inc,
    output logic                      inc_valid,
    output logic [fm_pkg::chan_w-1:0] inc_chan
);

    logic [2:0]               octave;
    logic [3:0]               note;
    logic [5:0]               frac;
    logic [3:0]               note_idx;
    logic [2:0]               oct_shift;
    logic [fm_pkg::inc_w-1:0] lin_inc;

    assign octave = kcex[12:10];
    assign note   = kcex[9:6];
    assign frac   = kcex[5:0];

    // three valid notes in every group of four codes.
    assign note_idx = ({2'b0, note[3:2]} * 4'd3) + {2'b0, note[1:0]};

    // the largest entry plus 63 steps stays below 2**inc_w.
    assign lin_inc   = fm_pkg::note_base[note_idx] + fm_pkg::note_step[note_idx] * frac;
    assign oct_shift = 3'd7 - octave;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            inc_valid <= 1'b0;
        end else if (!stall) begin
            inc_valid <= slot_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            inc      <= lin_inc >> oct_shift;
            inc_chan <= slot_chan;
        end
    end

endmodule

`default_nettype wire

/* design/fm_pkg.sv */
`default_nettype none

package fm_pkg;

    localparam int num_chan = 8;
    localparam int chan_w   = 3;

    // key code holds the octave in its upper 3 bits and the note code in the lower 4.
    localparam int kc_w     = 7;
    localparam int kf_w     = 6;
    localparam int kcex_w   = 13;
    localparam int mod_w    = 9;
    localparam int pmd_w    = 7;
    localparam int phase_w  = 20;
    localparam int inc_w    = 17;

    // highest reachable key, octave 7, note 14, fraction 63.
    localparam logic [kcex_w-1:0] kcex_max = {3'd7, 4'd14, 6'd63};

    // octave 7 increments at fraction 0, indexed by valid note order.
    localparam logic [inc_w-1:0] note_base [12] = '{
        17'd40000, 17'd42379, 17'd44898, 17'd47568,
        17'd50397, 17'd53394, 17'd56569, 17'd59932,
        17'd63496, 17'd67272, 17'd71272, 17'd75510
    };

    // increment added per fraction step, so 64 steps reach the next note.
    localparam logic [inc_w-1:0] note_step [12] = '{
        17'd37, 17'd39, 17'd41, 17'd44,
        17'd46, 17'd49, 17'd52, 17'd55,
        17'd59, 17'd62, 17'd66, 17'd70
    };

endpackage

`default_nettype wire

/* design/fm_pm_keycode.sv */
`default_nettype none

module fm_pm_keycode (
    input  logic [fm_pkg::kc_w-1:0]   kc,
    input  logic [fm_pkg::kf_w-1:0]   kf,
    input  logic [fm_pkg::mod_w-1:0]  mod,
    input  logic                      mod_add,
    output logic [fm_pkg::kcex_w-1:0] kcex
);

    logic [fm_pkg::kc_w-1:0] kc_fix;
    logic                    kc_ovf;
    logic [9:0]              up_lim;
    logic [1:0]              up_skip;
    logic [13:0]             up_sum;
    logic [13:0]             up_res;
    logic signed [9:0]       dn_lim;
    logic [1:0]              dn_skip;
    logic [13:0]             dn_sum;
    logic [13:0]             dn_res;

    // a gap note behaves as the valid note right above it.
    always_comb begin
        if (kc[1:0] == 2'b11) begin
            {kc_ovf, kc_fix} = {1'b0, kc} + 8'd1;
        end else begin
            {kc_ovf, kc_fix} = {1'b0, kc};
        end
    end

    // every gap crossed on the way up costs one more note of 64 fraction steps.
    always_comb begin
        up_lim = {1'b0, mod} + {4'd0, kf};
        case (kc_fix[1:0])
            2'd1:    up_skip = (up_lim >= 10'd384) ? 2'd2 : (up_lim >= 10'd192) ? 2'd1 : 2'd0;
            2'd2:    up_skip = (up_lim >= 10'd512) ? 2'd3 : (up_lim >= 10'd320) ? 2'd2 :
                               (up_lim >= 10'd128) ? 2'd1 : 2'd0;
            default: up_skip = (up_lim >= 10'd448) ? 2'd2 : (up_lim >= 10'd256) ? 2'd1 : 2'd0;
        endcase
        up_sum = {1'b0, kc_fix, kf} + {6'd0, up_skip, 6'd0} + {5'd0, mod};
        up_res = (up_sum[7:6] == 2'b11) ? up_sum + 14'd64 : up_sum;
    end

    // going down, the distance to the gap below depends on the note position.
    always_comb begin
        dn_lim = $signed({1'b0, mod}) - $signed({4'd0, kf});
        case (kc_fix[1:0])
            2'd1:    dn_skip = (dn_lim >= 10'sd321) ? 2'd2 : (dn_lim >= 10'sd129) ? 2'd1 : 2'd0;
            2'd2:    dn_skip = (dn_lim >= 10'sd385) ? 2'd2 : (dn_lim >= 10'sd193) ? 2'd1 : 2'd0;
            default: dn_skip = (dn_lim >= 10'sd449) ? 2'd3 : (dn_lim >= 10'sd257) ? 2'd2 :
                               (dn_lim >= 10'sd65) ? 2'd1 : 2'd0;
        endcase
        dn_sum = {1'b0, kc_fix, kf} - {6'd0, dn_skip, 6'd0} - {5'd0, mod};
        dn_res = (dn_sum[7:6] == 2'b11) ? dn_sum - 14'd64 : dn_sum;
    end

    always_comb begin
        if (kc_ovf) begin
            kcex = fm_pkg::kcex_max;
        end else if (mod_add) begin
            kcex = up_res[13] ? fm_pkg::kcex_max : up_res[12:0];
        end else begin
            // a borrow out of the top bit means we went below zero.
            kcex = dn_res[13] ? '0 : dn_res[12:0];
        end
    end

endmodule

`default_nettype wire

/* design/fm_slot_ctrl.sv */
`default_nettype none

module fm_slot_ctrl (
    input  logic                      clk,
    input  logic                      arst_n,
    output logic                      wr_ready,
    input  logic                      out_valid,
    input  logic                      out_ready,
    output logic                      slot_valid,
    output logic [fm_pkg::chan_w-1:0] slot_chan,
    output logic                      stall,
    output logic                      frame_tick
);

    typedef enum logic [1:0] {
        st_win,
        st_run,
        st_drain
    } state_t;

    state_t state;
    logic   inc_busy;

    assign stall      = out_valid && !out_ready;
    assign slot_valid = (state == st_run);
    assign wr_ready   = (state == st_win);
    assign frame_tick = (state == st_win);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            // the pipeline is empty after reset, so drain falls straight through.
            state     <= st_drain;
            slot_chan <= '0;
            inc_busy  <= 1'b0;
        end else begin
            // tracks whether the increment stage holds a slot.
            if (!stall) begin
                inc_busy <= slot_valid;
            end

            case (state)
                st_win: begin
                    state <= st_run;
                end
                st_run: begin
                    if (!stall) begin
                        if (int'(slot_chan) == fm_pkg::num_chan - 1) begin
                            slot_chan <= '0;
                            state     <= st_drain;
                        end else begin
                            slot_chan <= slot_chan + 1'b1;
                        end
                    end
                end
                st_drain: begin
                    if (!inc_busy && !out_valid) begin
                        state <= st_win;
                    end
                end
                default: begin
                    state <= st_drain;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* filelist.f */
design/fm_pkg.sv
design/fm_pm_keycode.sv
design/fm_lfo.sv
design/fm_slot_ctrl.sv
design/fm_phase_inc.sv
design/fm_phase_acc.sv
design/fm_pg_top.sv
verification/fm_pg_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module fm_pg_tb -f filelist.f -o fm_pg_sim
./obj_dir/fm_pg_sim | tee sim.log

if grep -q "TESTS FAILED" sim.log; then
    echo "simulation failed"
    exit 1
fi
grep -q "TESTS PASSED" sim.log
echo "simulation passed"

/* verification/fm_pg_tb.sv */
`default_nettype none

module fm_pg_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int n_frames    = 420;
    localparam int watchdog_ns = n_frames * 12 * 20;
    localparam int lin_top     = 8 * 12 * 64 - 1;

    // octave 7 increments at fraction 0 and per fraction step, in note order.
    localparam int base_tab [12] = '{
        40000, 42379, 44898, 47568, 50397, 53394,
        56569, 59932, 63496, 67272, 71272, 75510
    };
    localparam int step_tab [12] = '{
        37, 39, 41, 44, 46, 49, 52, 55, 59, 62, 66, 70
    };

    logic                       clk;
    logic                       arst_n;
    logic                       wr_valid;
    logic                       wr_ready;
    logic [fm_pkg::chan_w-1:0]  wr_chan;
    logic [fm_pkg::kc_w-1:0]    wr_kc;
    logic [fm_pkg::kf_w-1:0]    wr_kf;
    logic [fm_pkg::pmd_w-1:0]   pmd;
    logic [3:0]                 lfo_rate;
    logic                       out_valid;
    logic                       out_ready;
    logic [fm_pkg::chan_w-1:0]  out_chan;
    logic [fm_pkg::phase_w-1:0] out_phase;

    int                         m_kc [8];
    int                         m_kf [8];
    logic [fm_pkg::phase_w-1:0] m_phase [8];
    int                         lfo_k;
    int                         presc;
    int                         m_mod;
    bit                         m_add;
    int                         xfer_cnt   = 0;
    int                         win_cnt    = 0;
    int                         value_errs = 0;
    int                         proto_errs = 0;
    logic [31:0]                rdy_seed   = 32'd29288;
    logic [31:0]                wr_seed    = 32'd29288;
    string                      test_name  = "reset";

    fm_pg_top u_fm_pg_top (
        .clk       (clk),
        .arst_n    (arst_n),
        .wr_valid  (wr_valid),
        .wr_ready  (wr_ready),
        .wr_chan   (wr_chan),
        .wr_kc     (wr_kc),
        .wr_kf     (wr_kf),
        .pmd       (pmd),
        .lfo_rate  (lfo_rate),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_chan  (out_chan),
        .out_phase (out_phase)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // signed triangle value after k LFO steps, zero at the start.
    function automatic int tri_value(input int k);
        int t;
        t = k % 256;
        return (t < 64)  ? 2 * t :
               (t < 128) ? 2 * (127 - t) :
               (t < 192) ? -2 * (t - 128) : -2 * (255 - t);
    endfunction

    // position of a key on a gapless scale with 64 fraction steps per note.
    // gap codes land on the next note by themselves.
    function automatic int key_linear(input int kc, input int kf);
        int note;
        note = kc % 16;
        return ((kc / 16) * 12 + (note / 4) * 3 + note % 4) * 64 + kf;
    endfunction

    function automatic int expected_inc(input int kc, input int kf, input int mod, input bit add);
        int lin;
        int oct;
        int idx;
        lin = key_linear(kc, kf);
        if (lin > lin_top) begin
            lin = lin_top;
        end else begin
            lin = add ? lin + mod : lin - mod;
            if (lin > lin_top) begin
                lin = lin_top;
            end else if (lin < 0) begin
                lin = 0;
            end
        end
        oct = lin / 768;
        idx = (lin % 768) / 64;
        return (base_tab[idx] + step_tab[idx] * (lin % 64)) >> (7 - oct);
    endfunction

    task automatic lfo_tick(input int depth, input int rate);
        int v;
        if (presc == rate) begin
            presc = 0;
            lfo_k = (lfo_k + 1) % 256;
            v     = tri_value(lfo_k);
            m_add = (v >= 0);
            m_mod = ((v < 0) ? -v : v) * depth / 32;
        end else begin
            presc = (presc + 1) % 16;
        end
    endtask

    task automatic check_output();
        int                         ch;
        int                         inc;
        logic [fm_pkg::phase_w-1:0] exp_phase;
        ch        = xfer_cnt % 8;
        inc       = expected_inc(m_kc[ch], m_kf[ch], m_mod, m_add);
        exp_phase = m_phase[ch] + 20'(inc);
        m_phase[ch] = exp_phase;
        xfer_cnt++;
        a_chan: assert (out_chan == 3'(ch)) else begin
            value_errs++;
            $display("Error %s: channel expected %0d, actual %0d", test_name, ch, out_chan);
        end
        a_phase: assert (out_phase == exp_phase) else begin
            value_errs++;
            $display("Error %s: channel %0d phase expected 0x%05h, actual 0x%05h",
                     test_name, ch, exp_phase, out_phase);
        end
    endtask

    // model of the frame sequence, driven by the transfers and write windows.
    always @(posedge clk) begin
        if (arst_n) begin
            if (out_valid && out_ready) begin
                check_output();
            end
            if (wr_ready) begin
                win_cnt++;
                a_count: assert (xfer_cnt == 8 * (win_cnt - 1)) else begin
                    value_errs++;
                    $display("Error %s: outputs before window expected %0d, actual %0d",
                             test_name, 8 * (win_cnt - 1), xfer_cnt);
                end
                lfo_tick(int'(pmd), int'(lfo_rate));
                if (wr_valid) begin
                    m_kc[wr_chan] = int'(wr_kc);
                    m_kf[wr_chan] = int'(wr_kf);
                end
            end
        end
    end

    always @(posedge clk) begin
        rdy_seed = lcg_step(rdy_seed);
        out_ready <= (rdy_seed[17:16] != 2'b00);
    end

    a_hold: assert property (@(posedge clk) disable iff (!arst_n)
        out_valid && !out_ready |=> out_valid && out_chan == $past(out_chan)
            && out_phase == $past(out_phase))
        else begin
            proto_errs++;
            $display("output dropped or changed while waiting for out_ready");
        end

    a_window: assert property (@(posedge clk) disable iff (!arst_n)
        wr_ready |-> !out_valid ##1 !wr_ready)
        else begin
            proto_errs++;
            $display("write window overlapped the output or lasted more than one cycle");
        end

    task automatic write_key(input int ch, input int kc, input int kf);
        wr_valid <= 1'b1;
        wr_chan  <= 3'(ch);
        wr_kc    <= 7'(kc);
        wr_kf    <= 6'(kf);
        do begin
            @(posedge clk);
        end while (!wr_ready);
        wr_valid <= 1'b0;
    endtask

    task automatic wait_frames(input int n);
        repeat (n) begin
            do begin
                @(posedge clk);
            end while (!wr_ready);
        end
    endtask

    task automatic random_writes(input int n);
        repeat (n) begin
            wr_seed = lcg_step(wr_seed);
            write_key(int'(wr_seed[28:26]), int'(wr_seed[25:19]), int'(wr_seed[18:13]));
        end
    endtask

    initial begin
        arst_n    = 1'b0;
        wr_valid  = 1'b0;
        wr_chan   = '0;
        wr_kc     = '0;
        wr_kf     = '0;
        pmd       = '0;
        lfo_rate  = '0;
        out_ready = 1'b0;
        lfo_k     = 0;
        presc     = 0;
        m_mod     = 0;
        m_add     = 1'b1;
        for (int i = 0; i < 8; i++) begin
            m_kc[i]    = 0;
            m_kf[i]    = 0;
            m_phase[i] = '0;
        end
        repeat (16) @(posedge clk);
        a_reset: assert (!wr_ready && !out_valid) else begin
            proto_errs++;
            $display("wr_ready or out_valid was high during reset");
        end
        arst_n <= 1'b1;

        // gap codes, the top gap code and both ends of the range.
        test_name = "static pitch";
        write_key(0, 7'h00, 0);
        write_key(1, 7'h45, 20);
        write_key(2, 7'h03, 10);
        write_key(3, 7'h3b, 63);
        write_key(4, 7'h2f, 5);
        write_key(5, 7'h7f, 30);
        write_key(6, 7'h7e, 63);
        write_key(7, 7'h16, 40);
        wait_frames(4);

        // a full triangle period at the deepest setting.
        test_name = "full depth";
        pmd <= 7'd127;
        wait_frames(260);
        random_writes(80);

        test_name = "slow lfo";
        pmd      <= 7'd45;
        lfo_rate <= 4'd3;
        random_writes(60);
        wait_frames(1);
        #1;

        $display("value errors: %0d, protocol errors: %0d, outputs checked: %0d",
                 value_errs, proto_errs, xfer_cnt);
        if (value_errs == 0 && proto_errs == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

    initial begin
        #(watchdog_ns);
        $display("watchdog expired after %0d ns, the frames did not complete", watchdog_ns);
        $display("TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire
